// ==== compile.f ====
rtl/rp_pkg.sv
rtl/adc_frontend.sv
rtl/dac_backend.sv
rtl/loopback_mux.sv
rtl/exp_gpio_mux.sv
rtl/pdm_dac.sv
rtl/rp_top.sv
tests/tb_rp_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the signal-path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_rp_top \
  --Mdir obj_dir -o sim_rp_top > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/sim_rp_top > sim.log 2>&1
run_status=$?

if grep -q "Result: FAILED" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulator exited with status $run_status, see sim.log"
  exit 1
fi
echo "simulation finished without failures"
exit 0

// ==== tests/tb_rp_top.sv ====
/*
  random testbench for rp_top with a cycle model of all paths
  inputs change on the falling edge, outputs compared on the falling edge
  PDM values are held for 255-cycle windows to check the count of ones
*/

`timescale 1ns/1ps
`default_nettype none

module tb_rp_top;

  localparam int CHN     = 2;
  localparam int PDM_CHN = 4;
  localparam int WIN     = 255;
  localparam int N_WIN   = 8;
  localparam int N_CYC   = N_WIN * WIN;
  // twice the planned run, in ns
  localparam int WDOG_NS = 2 * (N_CYC + 10) * 8;

  // magnitude masks, sign kept and the rest inverted
  localparam logic [rp_pkg::ADC_DW-1:0] ADC_MAG = {1'b0, {(rp_pkg::ADC_DW-1){1'b1}}};
  localparam logic [rp_pkg::DAC_DW-1:0] DAC_MAG = {1'b0, {(rp_pkg::DAC_DW-1){1'b1}}};

  logic adc_clk;
  logic top_rst;
  logic [CHN-1:0][rp_pkg::ADC_DW-1:0]     adc_dat_i;
  rp_pkg::dac_sample_t [CHN-1:0]          gen_dat_i;
  logic [CHN-1:0]                         gen_vld_i;
  rp_pkg::loop_mode_e [CHN-1:0]           loop_i;
  rp_pkg::adc_sample_t [CHN-1:0]          osc_dat_o;
  logic [CHN-1:0][rp_pkg::DAC_DW-1:0]     dac_dat_o;
  logic [rp_pkg::EXP_W-1:0]               exp_mode_i;
  logic [rp_pkg::EXP_W-1:0]               gpio_out_i;
  logic [rp_pkg::EXP_W-1:0]               gpio_tri_i;
  logic [rp_pkg::EXP_W-1:0]               lg_dat_i;
  logic [rp_pkg::EXP_W-1:0]               lg_oe_i;
  logic [rp_pkg::EXP_W-1:0]               exp_i;
  logic [rp_pkg::EXP_W-1:0]               exp_o;
  logic [rp_pkg::EXP_W-1:0]               exp_oe_o;
  logic [rp_pkg::EXP_W-1:0]               gpio_in_o;
  logic [rp_pkg::EXP_W-1:0]               la_dat_o;
  logic [PDM_CHN-1:0][rp_pkg::PDM_DW-1:0] pdm_cfg_i;
  logic [PDM_CHN-1:0]                     pdm_o;

  // model state
  logic [CHN-1:0][rp_pkg::ADC_DW-1:0] osc_m;
  logic [CHN-1:0][rp_pkg::ADC_DW-1:0] adc_st;
  logic [CHN-1:0][rp_pkg::DAC_DW-1:0] dac_m;
  logic [CHN-1:0][rp_pkg::DAC_DW-1:0] gen_st;
  logic [CHN-1:0]                     vld_st;
  logic [rp_pkg::EXP_W-1:0]           exp_m;
  logic [rp_pkg::EXP_W-1:0]           oe_m;
  logic [rp_pkg::EXP_W-1:0]           in_m;
  logic [PDM_CHN-1:0]                 pdm_m;
  int                                 acc_m [PDM_CHN];
  int                                 pdm_sum;

  // PDM window bookkeeping
  int                                 ones_cnt [PDM_CHN];
  int                                 pdm_val [PDM_CHN];

  integer      seed = 32'h1ded_46bf;
  logic [31:0] rnd;

  rp_top #(
    .CHN     (CHN),
    .PDM_CHN (PDM_CHN)
  ) rp_top_inst (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .adc_dat_i  (adc_dat_i),
    .gen_dat_i  (gen_dat_i),
    .gen_vld_i  (gen_vld_i),
    .loop_i     (loop_i),
    .osc_dat_o  (osc_dat_o),
    .dac_dat_o  (dac_dat_o),
    .exp_mode_i (exp_mode_i),
    .gpio_out_i (gpio_out_i),
    .gpio_tri_i (gpio_tri_i),
    .lg_dat_i   (lg_dat_i),
    .lg_oe_i    (lg_oe_i),
    .exp_i      (exp_i),
    .exp_o      (exp_o),
    .exp_oe_o   (exp_oe_o),
    .gpio_in_o  (gpio_in_o),
    .la_dat_o   (la_dat_o),
    .pdm_cfg_i  (pdm_cfg_i),
    .pdm_o      (pdm_o)
  );

  initial begin
    adc_clk = 1'b0;
    forever #4 adc_clk = ~adc_clk;
  end

  initial begin
    #(WDOG_NS);
    $display("watchdog timeout, the test did not reach its end in time");
    $display("Result: FAILED");
    $fatal(1);
  end

  ////////////////////
  // cycle model
  ////////////////////

  always @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      osc_m  = '0;
      adc_st = '0;
      // mid-scale offset code
      for (int c = 0; c < CHN; c++) dac_m[c] = DAC_MAG;
      gen_st = '0;
      vld_st = '0;
      exp_m  = '0;
      oe_m   = '0;
      in_m   = '0;
      pdm_m  = '0;
      for (int p = 0; p < PDM_CHN; p++) acc_m[p] = 0;
    end else begin
      for (int c = 0; c < CHN; c++) begin
        // scope sees the ADC two cycles late, or the generator one cycle late
        // input register keeps the raw code, converted on the way out
        if (loop_i[c] == rp_pkg::LOOP_DAC_ADC) osc_m[c] = {gen_dat_i[c], 2'b00};
        else osc_m[c] = adc_st[c] ^ ADC_MAG;
        adc_st[c] = adc_dat_i[c];
        // DAC loads the strobed sample one stage later
        if (vld_st[c]) dac_m[c] = gen_st[c] ^ DAC_MAG;
        vld_st[c] = gen_vld_i[c] && (loop_i[c] == rp_pkg::LOOP_OFF);
        gen_st[c] = gen_dat_i[c];
      end
      for (int b = 0; b < rp_pkg::EXP_W; b++) begin
        exp_m[b] = exp_mode_i[b] ? lg_dat_i[b] : gpio_out_i[b];
        oe_m[b]  = exp_mode_i[b] ? lg_oe_i[b] : !gpio_tri_i[b];
      end
      in_m = exp_i;
      // first-order modulator, modulus 255
      for (int p = 0; p < PDM_CHN; p++) begin
        pdm_sum = acc_m[p] + int'(pdm_cfg_i[p]);
        pdm_m[p] = (pdm_sum >= int'(rp_pkg::PDM_RNG));
        acc_m[p] = pdm_m[p] ? pdm_sum - int'(rp_pkg::PDM_RNG) : pdm_sum;
      end
    end
  end

  ////////////////////
  // checks and stimulus
  ////////////////////

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    assert (got === exp) else begin
      $display("FAIL at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      $display("Result: FAILED");
      $fatal(1);
    end
  endtask

  task automatic scan_outputs();
    compare_value("osc_dat_o", 64'(osc_dat_o), 64'(osc_m));
    compare_value("dac_dat_o", 64'(dac_dat_o), 64'(dac_m));
    compare_value("exp_o", 64'(exp_o), 64'(exp_m));
    compare_value("exp_oe_o", 64'(exp_oe_o), 64'(oe_m));
    compare_value("gpio_in_o", 64'(gpio_in_o), 64'(in_m));
    compare_value("la_dat_o", 64'(la_dat_o), 64'(in_m));
    compare_value("pdm_o", 64'(pdm_o), 64'(pdm_m));
  endtask

  task automatic drive_stimulus();
    for (int c = 0; c < CHN; c++) begin
      rnd = $random(seed);
      adc_dat_i[c] = rnd[rp_pkg::ADC_DW-1:0];
      gen_dat_i[c] = rnd[rp_pkg::DAC_DW+15:16];
      gen_vld_i[c] = rnd[30];
      // rare mode flips give runs in both modes
      if (rnd[31] && rnd[29:27] == 3'd0) begin
        loop_i[c] = (loop_i[c] == rp_pkg::LOOP_OFF) ? rp_pkg::LOOP_DAC_ADC : rp_pkg::LOOP_OFF;
      end
    end
    rnd = $random(seed);
    exp_mode_i = rnd[15:0];
    gpio_out_i = rnd[31:16];
    rnd = $random(seed);
    gpio_tri_i = rnd[15:0];
    lg_dat_i   = rnd[31:16];
    rnd = $random(seed);
    lg_oe_i = rnd[15:0];
    exp_i   = rnd[31:16];
  endtask

  initial begin
    adc_dat_i  = '0;
    gen_dat_i  = '0;
    gen_vld_i  = '0;
    for (int c = 0; c < CHN; c++) loop_i[c] = rp_pkg::LOOP_OFF;
    exp_mode_i = '0;
    gpio_out_i = '0;
    gpio_tri_i = '0;
    lg_dat_i   = '0;
    lg_oe_i    = '0;
    exp_i      = '0;
    pdm_cfg_i  = '0;
    top_rst    = 1'b1;
    repeat (3) @(posedge adc_clk);
    @(negedge adc_clk);
    // reset values, DAC at mid-scale and all drivers off
    for (int c = 0; c < CHN; c++) begin
      compare_value("dac_dat_o reset", 64'(dac_dat_o[c]), 64'(DAC_MAG));
    end
    compare_value("exp_oe_o reset", 64'(exp_oe_o), 64'd0);
    compare_value("pdm_o reset", 64'(pdm_o), 64'd0);
    scan_outputs();
    top_rst = 1'b0;
    for (int k = 0; k <= N_CYC; k++) begin
      if (k > 0) begin
        @(negedge adc_clk);
        scan_outputs();
        for (int p = 0; p < PDM_CHN; p++) ones_cnt[p] += int'(pdm_o[p]);
      end
      if (k % WIN == 0) begin
        for (int p = 0; p < PDM_CHN; p++) begin
          if (k > 0) begin
            assert (ones_cnt[p] == pdm_val[p]) else begin
              $display("FAIL at %0t ns: pdm_o[%0d] gave %0d ones for value %0d",
                       $time, p, ones_cnt[p], pdm_val[p]);
              $display("Result: FAILED");
              $fatal(1);
            end
          end
          // new steady value for the next window
          rnd = $random(seed);
          pdm_cfg_i[p] = rnd[rp_pkg::PDM_DW-1:0];
          pdm_val[p]   = int'(rnd[rp_pkg::PDM_DW-1:0]);
          ones_cnt[p]  = 0;
        end
      end
      drive_stimulus();
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/rp_top.sv ====
/*
  signal-path core, single clock adc_clk and async reset top_rst
  former bus registers (loop mode, GPIO mode, PDM values) are plain inputs
  DAC channels leave as a packed vector, no interleaving
*/

`timescale 1ns/1ps
`default_nettype none

module rp_top #(
  parameter int unsigned CHN     = 2,
  parameter int unsigned PDM_CHN = 4
) (
  input  logic                                    adc_clk,
  input  logic                                    top_rst,
  // ADC pins and generator samples
  input  logic [CHN-1:0][rp_pkg::ADC_DW-1:0]      adc_dat_i,
  input  rp_pkg::dac_sample_t [CHN-1:0]           gen_dat_i,
  input  logic [CHN-1:0]                          gen_vld_i,
  input  rp_pkg::loop_mode_e [CHN-1:0]            loop_i,
  // oscilloscope samples and DAC pins
  output rp_pkg::adc_sample_t [CHN-1:0]           osc_dat_o,
  output logic [CHN-1:0][rp_pkg::DAC_DW-1:0]      dac_dat_o,
  // expansion connector
  input  logic [rp_pkg::EXP_W-1:0]                exp_mode_i,
  input  logic [rp_pkg::EXP_W-1:0]                gpio_out_i,
  input  logic [rp_pkg::EXP_W-1:0]                gpio_tri_i,
  input  logic [rp_pkg::EXP_W-1:0]                lg_dat_i,
  input  logic [rp_pkg::EXP_W-1:0]                lg_oe_i,
  input  logic [rp_pkg::EXP_W-1:0]                exp_i,
  output logic [rp_pkg::EXP_W-1:0]                exp_o,
  output logic [rp_pkg::EXP_W-1:0]                exp_oe_o,
  output logic [rp_pkg::EXP_W-1:0]                gpio_in_o,
  output logic [rp_pkg::EXP_W-1:0]                la_dat_o,
  // PDM analog outputs
  input  logic [PDM_CHN-1:0][rp_pkg::PDM_DW-1:0]  pdm_cfg_i,
  output logic [PDM_CHN-1:0]                      pdm_o
);

  // converted ADC samples
  rp_pkg::adc_sample_t [CHN-1:0] adc_smp;
  // generator samples toward the DAC
  rp_pkg::dac_sample_t [CHN-1:0] dac_smp;
  logic [CHN-1:0]                dac_vld;

  ////////////////////
  // ADC and DAC path
  ////////////////////

  adc_frontend #(
    .CHN (CHN)
  ) adc_frontend_inst (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_dat_i (adc_dat_i),
    .adc_smp_o (adc_smp)
  );

  // loopback sits between the converters and the scope
  loopback_mux #(
    .CHN (CHN)
  ) loopback_mux_inst (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .loop_i    (loop_i),
    .adc_smp_i (adc_smp),
    .gen_dat_i (gen_dat_i),
    .gen_vld_i (gen_vld_i),
    .osc_dat_o (osc_dat_o),
    .dac_smp_o (dac_smp),
    .dac_vld_o (dac_vld)
  );

  dac_backend #(
    .CHN (CHN)
  ) dac_backend_inst (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .dac_smp_i (dac_smp),
    .dac_vld_i (dac_vld),
    .dac_dat_o (dac_dat_o)
  );

  ////////////////////
  // expansion and PDM
  ////////////////////

  exp_gpio_mux exp_gpio_mux_inst (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .exp_mode_i (exp_mode_i),
    .gpio_out_i (gpio_out_i),
    .gpio_tri_i (gpio_tri_i),
    .lg_dat_i   (lg_dat_i),
    .lg_oe_i    (lg_oe_i),
    .exp_i      (exp_i),
    .exp_o      (exp_o),
    .exp_oe_o   (exp_oe_o),
    .gpio_in_o  (gpio_in_o),
    .la_dat_o   (la_dat_o)
  );

  // slow analog outputs, range fixed in the package
  pdm_dac #(
    .PDM_CHN (PDM_CHN)
  ) pdm_dac_inst (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .pdm_cfg_i (pdm_cfg_i),
    .pdm_o     (pdm_o)
  );

endmodule

`default_nettype wire

// ==== rtl/pdm_dac.sv ====
/*
  first-order pulse-density modulators, one per channel
  fixed modulus PDM_RNG, a value of PDM_RNG gives a steady high
  a new value takes effect on the next clock, output is registered
*/

`timescale 1ns/1ps
`default_nettype none

module pdm_dac #(
  parameter int unsigned PDM_CHN = 4
) (
  input  logic                                    adc_clk,
  input  logic                                    top_rst,
  // density per channel
  input  logic [PDM_CHN-1:0][rp_pkg::PDM_DW-1:0]  pdm_cfg_i,
  // bitstream outputs
  output logic [PDM_CHN-1:0]                      pdm_o
);

  localparam int unsigned W = rp_pkg::PDM_DW;

  // modulus at sum width, one extra bit for the carry
  localparam logic [W:0] RNG = (W+1)'(rp_pkg::PDM_RNG);

  for (genvar c = 0; c < PDM_CHN; c++) begin : g_chn

    logic [W-1:0] acc;
    logic [W:0]   sum;
    logic [W:0]   dif;
    logic         ovf;

    // accumulate, wrap at the modulus
    assign sum = {1'b0, acc} + {1'b0, pdm_cfg_i[c]};
    assign dif = sum - RNG;
    assign ovf = (sum >= RNG);

    always_ff @(posedge adc_clk or posedge top_rst) begin
      if (top_rst) begin
        acc      <= '0;
        pdm_o[c] <= 1'b0;
      end else begin
        // remainder always below the modulus
        acc      <= ovf ? dif[W-1:0] : sum[W-1:0];
        pdm_o[c] <= ovf;
      end
    end

  end

endmodule

`default_nettype wire

// ==== rtl/exp_gpio_mux.sv ====
/*
  expansion connector mux between processor GPIO and logic generator
  the selection and the pin inputs are registered, one cycle each
  gpio_tri_i of 1 is high impedance, exp_oe_o of 1 drives the pin
*/

`timescale 1ns/1ps
`default_nettype none

module exp_gpio_mux (
  input  logic                     adc_clk,
  input  logic                     top_rst,
  // per-bit mode, 1 selects the logic generator
  input  logic [rp_pkg::EXP_W-1:0] exp_mode_i,
  // processor GPIO
  input  logic [rp_pkg::EXP_W-1:0] gpio_out_i,
  input  logic [rp_pkg::EXP_W-1:0] gpio_tri_i,
  // logic generator
  input  logic [rp_pkg::EXP_W-1:0] lg_dat_i,
  input  logic [rp_pkg::EXP_W-1:0] lg_oe_i,
  // pins
  input  logic [rp_pkg::EXP_W-1:0] exp_i,
  output logic [rp_pkg::EXP_W-1:0] exp_o,
  output logic [rp_pkg::EXP_W-1:0] exp_oe_o,
  // sampled pins
  output logic [rp_pkg::EXP_W-1:0] gpio_in_o,
  output logic [rp_pkg::EXP_W-1:0] la_dat_o
);

  logic [rp_pkg::EXP_W-1:0] exp_in_r;

  ////////////////////
  // output side
  ////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      exp_o    <= '0;
      exp_oe_o <= '0;
    end else begin
      // bitwise select, mode 0 is the processor
      exp_o    <= (~exp_mode_i & gpio_out_i) | (exp_mode_i & lg_dat_i);
      // tristate is active high disable, flip it into an enable
      exp_oe_o <= (~exp_mode_i & ~gpio_tri_i) | (exp_mode_i & lg_oe_i);
    end
  end

  ////////////////////
  // input side
  ////////////////////

  // one sampling register shared by both consumers
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      exp_in_r <= '0;
    end else begin
      exp_in_r <= exp_i;
    end
  end

  assign gpio_in_o = exp_in_r;
  // analyzer tap sees the same sample
  assign la_dat_o  = exp_in_r;

endmodule

`default_nettype wire

// ==== rtl/loopback_mux.sv ====
/*
  per-channel DAC to ADC loopback router, all outputs registered
  LOOP_DAC_ADC feeds the shifted generator sample to the oscilloscope
  and blocks the DAC strobe, so the DAC holds its last value
  the loop path ignores gen_vld_i and takes a sample every cycle
*/

`timescale 1ns/1ps
`default_nettype none

module loopback_mux #(
  parameter int unsigned CHN = 2
) (
  input  logic                          adc_clk,
  input  logic                          top_rst,
  // routing control
  input  rp_pkg::loop_mode_e [CHN-1:0]  loop_i,
  // sources
  input  rp_pkg::adc_sample_t [CHN-1:0] adc_smp_i,
  input  rp_pkg::dac_sample_t [CHN-1:0] gen_dat_i,
  input  logic [CHN-1:0]                gen_vld_i,
  // oscilloscope path
  output rp_pkg::adc_sample_t [CHN-1:0] osc_dat_o,
  // DAC path
  output rp_pkg::dac_sample_t [CHN-1:0] dac_smp_o,
  output logic [CHN-1:0]                dac_vld_o
);

  for (genvar c = 0; c < CHN; c++) begin : g_chn

    rp_pkg::dac_sample_t gen_s;
    rp_pkg::adc_sample_t gen_ext;
    logic                in_loop;

    assign in_loop = (loop_i[c] == rp_pkg::LOOP_DAC_ADC);

    // sign extend first, then align to ADC full scale
    assign gen_s   = gen_dat_i[c];
    assign gen_ext = rp_pkg::adc_sample_t'(gen_s) <<< rp_pkg::LOOP_SHIFT;

    ////////////////////
    // control and scope
    ////////////////////

    always_ff @(posedge adc_clk or posedge top_rst) begin
      if (top_rst) begin
        osc_dat_o[c] <= '0;
        dac_vld_o[c] <= 1'b0;
      end else begin
        // scope source select
        osc_dat_o[c] <= in_loop ? gen_ext : adc_smp_i[c];
        // strobe only reaches the DAC outside the loop
        dac_vld_o[c] <= gen_vld_i[c] & ~in_loop;
      end
    end

    // data follows every cycle, qualified by dac_vld_o
    always_ff @(posedge adc_clk or posedge top_rst) begin
      if (top_rst) begin
        dac_smp_o[c] <= '0;
      end else begin
        dac_smp_o[c] <= gen_dat_i[c];
      end
    end

  end

endmodule

`default_nettype wire

// ==== rtl/dac_backend.sv ====
/*
  DAC output register per channel, loads only on a valid strobe
  two's complement in, negative-slope offset code out
  reset drives mid-scale code until the first valid sample
*/

`timescale 1ns/1ps
`default_nettype none

module dac_backend #(
  parameter int unsigned CHN = 2
) (
  input  logic                                  adc_clk,
  input  logic                                  top_rst,
  // samples from the loopback router
  input  rp_pkg::dac_sample_t [CHN-1:0]         dac_smp_i,
  input  logic [CHN-1:0]                        dac_vld_i,
  // raw converter pins
  output logic [CHN-1:0][rp_pkg::DAC_DW-1:0]    dac_dat_o
);

  localparam int unsigned W = rp_pkg::DAC_DW;

  // largest positive offset code, analog zero
  localparam logic [W-1:0] DAC_MID = {1'b0, {(W-1){1'b1}}};

  for (genvar c = 0; c < CHN; c++) begin : g_chn

    // signed to offset code, same rule as the ADC side
    logic [W-1:0] dac_cnv;

    assign dac_cnv = {dac_smp_i[c][W-1], ~dac_smp_i[c][W-2:0]};

    // hold last value while no sample arrives
    always_ff @(posedge adc_clk or posedge top_rst) begin
      if (top_rst) begin
        dac_dat_o[c] <= DAC_MID;
      end else if (dac_vld_i[c]) begin
        dac_dat_o[c] <= dac_cnv;
      end
    end

  end

endmodule

`default_nettype wire

// ==== rtl/adc_frontend.sv ====
/*
  ADC input register, one per channel
  raw data is negative-slope offset code, output is two's complement
  one cycle from adc_dat_i to adc_smp_o
*/

`timescale 1ns/1ps
`default_nettype none

module adc_frontend #(
  parameter int unsigned CHN = 2
) (
  input  logic                                  adc_clk,
  input  logic                                  top_rst,
  // raw converter pins
  input  logic [CHN-1:0][rp_pkg::ADC_DW-1:0]    adc_dat_i,
  // converted samples
  output rp_pkg::adc_sample_t [CHN-1:0]         adc_smp_o
);

  localparam int unsigned W = rp_pkg::ADC_DW;

  // input register, would map into the IO block
  logic [CHN-1:0][W-1:0] adc_raw;

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      adc_raw <= '0;
    end else begin
      adc_raw <= adc_dat_i;
    end
  end

  ////////////////////
  // code conversion
  ////////////////////

  for (genvar c = 0; c < CHN; c++) begin : g_chn
    // negative slope, keep sign and flip the rest
    assign adc_smp_o[c] = {adc_raw[c][W-1], ~adc_raw[c][W-2:0]};
  end

endmodule

`default_nettype wire

// ==== rtl/rp_pkg.sv ====
/*
  shared widths, sample types and the loop mode for the signal-path core
  ADC_DW must equal DAC_DW + LOOP_SHIFT for the loopback path
  PDM_RNG must fit in PDM_DW bits
*/

`default_nettype none

package rp_pkg;

  // converter data widths
  localparam int unsigned ADC_DW     = 16;
  localparam int unsigned DAC_DW     = 14;
  // generator to oscilloscope alignment
  localparam int unsigned LOOP_SHIFT = 2;

  // expansion connector, both rows
  localparam int unsigned EXP_W      = 16;

  // PDM value width and modulus
  localparam int unsigned PDM_DW     = 8;
  localparam int unsigned PDM_RNG    = 255;

  // two's complement samples
  typedef logic signed [ADC_DW-1:0] adc_sample_t;
  typedef logic signed [DAC_DW-1:0] dac_sample_t;

  // per-channel routing of the generator stream
  typedef enum logic {
    LOOP_OFF     = 1'b0,
    LOOP_DAC_ADC = 1'b1
  } loop_mode_e;

endpackage

`default_nettype wire
